// ==== llq_defines.svh ====
/*
  Size settings for the linked-list queue manager.
  Included by the package and by every RTL file.
*/
`ifndef LLQ_DEFINES_SVH
`define LLQ_DEFINES_SVH

`define LLQ_DATA_W 32  // Lookup data word width
`define LLQ_CTXTS  4   // Queue contexts
`define LLQ_LINKS  16  // Link slots in the shared pool

`endif

// ==== llq_pkg.sv ====
/*
  Word types and per-context queue state of the queue manager.
  Imported by the interfaces and the RTL modules.
*/
`include "llq_defines.svh"

package llq_pkg;

  typedef logic [`LLQ_DATA_W-1:0]         data_t;     // Lookup data
  typedef logic [$clog2(`LLQ_CTXTS)-1:0]  ctxt_t;     // Context index
  typedef logic [$clog2(`LLQ_LINKS)-1:0]  addr_t;     // Link slot address
  typedef logic [`LLQ_CTXTS-1:0]          ctxt_vec_t; // One bit per context
  typedef logic [`LLQ_LINKS-1:0]          slot_vec_t; // One bit per slot

  // Head is the newest slot, tail the oldest
  typedef struct packed {
    logic  empty;
    addr_t head;
    addr_t tail;
  } queue_state_t;

endpackage

// ==== llq_intf.sv ====
/*
  Internal interfaces between the controller and its storage blocks.
  The controller always takes the master modport.
*/
`timescale 1ns/100ps
`include "llq_defines.svh"

// Slot allocation and release
interface free_list_if;
  import llq_pkg::*;

  logic  alloc;     // Take alloc_id at the edge
  addr_t alloc_id;  // Lowest free slot
  logic  all_alloc; // Pool exhausted
  logic  clear;     // Free clear_id at the edge
  addr_t clear_id;

  modport master (
    output alloc, clear, clear_id,
    input  alloc_id, all_alloc
  );
  modport slave (
    input  alloc, clear, clear_id,
    output alloc_id, all_alloc
  );
endinterface

// Context state read and update
interface state_upd_if;
  import llq_pkg::*;

  ctxt_t        rd_ctxt;
  queue_state_t rd_state; // Combinational from flops
  logic         wr_en;
  ctxt_t        wr_ctxt;
  queue_state_t wr_state;

  modport master (
    output rd_ctxt, wr_en, wr_ctxt, wr_state,
    input  rd_state
  );
  modport slave (
    input  rd_ctxt, wr_en, wr_ctxt, wr_state,
    output rd_state
  );
endinterface

// Next-link memory port
interface link_table_if;
  import llq_pkg::*;

  logic  en;
  logic  wen;
  addr_t addr;
  addr_t din;
  addr_t dout; // One cycle after a read

  modport master (output en, wen, addr, din, input dout);
  modport slave  (input en, wen, addr, din, output dout);
endinterface

// ==== llq_cntrl.sv ====
/*
  Command controller of the queue manager.
  Accepts one push or pop per cycle, updates context state in the same cycle
  and registers the lookup. A pop holds off the next cycle's command.
*/
`timescale 1ns/100ps
`include "llq_defines.svh"

module llq_cntrl (
  input  logic           clk,
  input  logic           rst,
  input  logic           cmd_pass,
  input  logic           cmd_push,
  input  llq_pkg::ctxt_t cmd_ctxt,
  input  llq_pkg::data_t cmd_data,
  output logic           cmd_accept,
  output logic           lkup_pass_r,
  output logic           lkup_rnw_r,
  output llq_pkg::addr_t lkup_addr_r,
  output llq_pkg::data_t lkup_data_r,
  output logic           lkup_empty_fault_r,
  input  logic           full,
  free_list_if.master    free,
  state_upd_if.master    state,
  link_table_if.master   link
);
  import llq_pkg::*;

  logic         cmd_acc;     // Command taken this cycle
  logic         push_acc;
  logic         pop_acc;
  logic         pop_go;      // Pop on a non-empty context
  logic         pop_rd;      // Pop that needs the next link
  logic         pop_last;
  queue_state_t cur;
  queue_state_t nxt;
  logic         pop_stall_r; // Pop accepted last cycle
  logic         tail_upd_r;  // Link read in flight
  ctxt_t        tail_ctxt_r; // Context awaiting its new tail

  always_comb begin
    cmd_accept = ~pop_stall_r & ~(cmd_push & full);
    cmd_acc    = cmd_pass & cmd_accept;
    push_acc   = cmd_acc & cmd_push;
    pop_acc    = cmd_acc & ~cmd_push;
  end

  // No command is taken while the tail update runs, so the read port is free
  assign state.rd_ctxt = tail_upd_r ? tail_ctxt_r : cmd_ctxt;
  assign cur           = state.rd_state;
  assign pop_last      = (cur.head == cur.tail);
  assign pop_go        = pop_acc & ~cur.empty;
  assign pop_rd        = pop_go & ~pop_last;

  always_comb begin
    nxt = cur;
    if (tail_upd_r) begin
      nxt.tail = link.dout;           // Oldest moves to its successor
    end else if (cmd_push) begin
      nxt.head  = free.alloc_id;
      if (cur.empty)
        nxt.tail = free.alloc_id;     // First entry is both ends
      nxt.empty = 1'b0;
    end else begin
      nxt.empty = 1'b1;               // Last entry leaving
    end
  end

  assign state.wr_en    = tail_upd_r | push_acc | (pop_go & pop_last);
  assign state.wr_ctxt  = state.rd_ctxt;
  assign state.wr_state = nxt;

  assign free.alloc    = push_acc;
  assign free.clear    = pop_go;
  assign free.clear_id = cur.tail;

  // Push links old head to new slot, pop reads the tail's successor
  assign link.en   = (push_acc & ~cur.empty) | pop_rd;
  assign link.wen  = cmd_push;
  assign link.addr = cmd_push ? cur.head : cur.tail;
  assign link.din  = free.alloc_id;

  always_ff @(posedge clk) begin
    if (rst) begin
      pop_stall_r <= 1'b0;
      tail_upd_r  <= 1'b0;
      lkup_pass_r <= 1'b0;
    end else begin
      pop_stall_r <= pop_acc;  // Faulted pops stall too
      tail_upd_r  <= pop_rd;
      lkup_pass_r <= cmd_acc;
    end
  end

  always_ff @(posedge clk) begin
    if (pop_rd)
      tail_ctxt_r <= cmd_ctxt;
    if (cmd_acc) begin
      lkup_rnw_r         <= ~cmd_push;
      lkup_addr_r        <= cmd_push ? free.alloc_id : cur.tail;
      lkup_data_r        <= cmd_data;
      lkup_empty_fault_r <= pop_acc & cur.empty;
    end
  end

  // Pending tail update owns the state and link ports
  a_pop_stall: assert property (@(posedge clk) disable iff (rst)
    tail_upd_r |-> !cmd_acc);

endmodule

// ==== llq_free_list.sv ====
/*
  Free slot pool of the queue manager.
  Bitset of allocated slots with a lowest-free search.
*/
`timescale 1ns/100ps
`include "llq_defines.svh"

module llq_free_list (
  input  logic      clk,
  input  logic      rst,
  free_list_if.slave fl,
  output logic      full_r
);
  import llq_pkg::*;

  slot_vec_t alloc_r; // Set bit is a slot in use
  addr_t     low_id;
  logic      all_set;

  // Lowest clear bit wins, scanned from the top down
  always_comb begin
    low_id = '0;
    for (int i = `LLQ_LINKS - 1; i >= 0; i--) begin
      if (!alloc_r[i])
        low_id = addr_t'(i);
    end
  end

  assign all_set      = &alloc_r;
  assign fl.alloc_id  = low_id;
  assign fl.all_alloc = all_set;
  assign full_r       = all_set; // Flops only, so valid the cycle after the edge

  always_ff @(posedge clk) begin
    if (rst) begin
      alloc_r <= '0;
    end else begin
      if (fl.alloc)
        alloc_r[fl.alloc_id] <= 1'b1;
      if (fl.clear)
        alloc_r[fl.clear_id] <= 1'b0;
    end
  end

  a_alloc_free: assert property (@(posedge clk) disable iff (rst)
    fl.alloc |-> !alloc_r[fl.alloc_id]);
  a_clear_used: assert property (@(posedge clk) disable iff (rst)
    fl.clear |-> alloc_r[fl.clear_id]);

endmodule

// ==== llq_state_table.sv ====
/*
  Per-context queue state held in flops.
  One combinational read port, one write port at the clock edge.
  All contexts come out of reset empty.
*/
`timescale 1ns/100ps
`include "llq_defines.svh"

module llq_state_table (
  input  logic               clk,
  input  logic               rst,
  state_upd_if.slave         st,
  output llq_pkg::ctxt_vec_t empty_r
);
  import llq_pkg::*;

  queue_state_t entry_r [`LLQ_CTXTS];

  assign st.rd_state = entry_r[st.rd_ctxt];

  // Status gathered straight from the entries
  always_comb begin
    for (int c = 0; c < `LLQ_CTXTS; c++)
      empty_r[c] = entry_r[c].empty;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int c = 0; c < `LLQ_CTXTS; c++) begin
        entry_r[c].empty <= 1'b1;
        entry_r[c].head  <= '0;
        entry_r[c].tail  <= '0;
      end
    end else if (st.wr_en) begin
      entry_r[st.wr_ctxt] <= st.wr_state;
    end
  end

endmodule

// ==== llq_link_table.sv ====
/*
  Next-link memory, one entry per slot.
  Single port, registered read data.
*/
`timescale 1ns/100ps
`include "llq_defines.svh"

module llq_link_table (
  input  logic        clk,
  link_table_if.slave lt
);

  logic [$clog2(`LLQ_LINKS)-1:0] mem [`LLQ_LINKS]; // Successor of each slot

  always_ff @(posedge clk) begin
    if (lt.en) begin
      if (lt.wen)
        mem[lt.addr] <= lt.din;
      else
        lt.dout <= mem[lt.addr]; // Held until the next read
    end
  end

  // An unknown address would corrupt an arbitrary link
  a_addr_known: assert property (@(posedge clk)
    lt.en |-> !$isunknown(lt.addr));

endmodule

// ==== llq_top.sv ====
/*
  Top level of the linked-list queue manager.
  Connects the controller to the free list, state table and link table.
  Commands enter on the cmd_* strobe, lookups leave one cycle later.
*/
`timescale 1ns/100ps
`include "llq_defines.svh"

module llq_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               cmd_pass,
  input  logic               cmd_push,
  input  llq_pkg::ctxt_t     cmd_ctxt,
  input  llq_pkg::data_t     cmd_data,
  output logic               cmd_accept,
  output logic               lkup_pass_r,
  output logic               lkup_rnw_r,
  output llq_pkg::addr_t     lkup_addr_r,
  output llq_pkg::data_t     lkup_data_r,
  output logic               lkup_empty_fault_r,
  output llq_pkg::ctxt_vec_t empty_r,
  output logic               full_r
);

  free_list_if  fl_if ();
  state_upd_if  st_if ();
  link_table_if lt_if ();

  llq_cntrl u_cntrl (
    .clk                (clk),
    .rst                (rst),
    .cmd_pass           (cmd_pass),
    .cmd_push           (cmd_push),
    .cmd_ctxt           (cmd_ctxt),
    .cmd_data           (cmd_data),
    .cmd_accept         (cmd_accept),
    .lkup_pass_r        (lkup_pass_r),
    .lkup_rnw_r         (lkup_rnw_r),
    .lkup_addr_r        (lkup_addr_r),
    .lkup_data_r        (lkup_data_r),
    .lkup_empty_fault_r (lkup_empty_fault_r),
    .full               (full_r),  // Pool status feeds back into accept
    .free               (fl_if.master),
    .state              (st_if.master),
    .link               (lt_if.master)
  );

  llq_free_list u_free_list (
    .clk    (clk),
    .rst    (rst),
    .fl     (fl_if.slave),
    .full_r (full_r)
  );

  llq_state_table u_state_table (
    .clk     (clk),
    .rst     (rst),
    .st      (st_if.slave),
    .empty_r (empty_r)
  );

  llq_link_table u_link_table (
    .clk (clk),
    .lt  (lt_if.slave)
  );

endmodule

// ==== tb_llq_checks.svh ====
/*
  Error counters, typed compare tasks and the Galois LFSR of the testbench.
  Included inside the tb_llq module body, after the package import.
*/
`ifndef TB_LLQ_CHECKS_SVH
`define TB_LLQ_CHECKS_SVH

int mismatch_count = 0; // Wrong values seen
int fail_count     = 0; // Timeouts and table inconsistencies

// One Galois step, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  logic [31:0] n;
  n = s >> 1;
  if (s[0])
    n = n ^ 32'h8020_0003;
  return n;
endfunction

task automatic addr_cmp(input string name, input addr_t got, input addr_t exp);
  if (got !== exp) begin
    mismatch_count++;
    $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
  end
endtask

task automatic data_cmp(input string name, input data_t got, input data_t exp);
  if (got !== exp) begin
    mismatch_count++;
    $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
  end
endtask

task automatic vec_cmp(input string name, input ctxt_vec_t got, input ctxt_vec_t exp);
  if (got !== exp) begin
    mismatch_count++;
    $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
  end
endtask

task automatic bit_cmp(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    mismatch_count++;
    $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
  end
endtask

`endif

// ==== tb_llq.sv ====
/*
  Testbench for the queue manager top level.
  Applies a command table, predicts lookups and status from a queue model
  and reports the error counts at the end.
*/
`timescale 1ns/100ps
`include "llq_defines.svh"

module tb_llq;
  import llq_pkg::*;

  `include "tb_llq_checks.svh"

  typedef struct packed {
    logic  pass;  // Command valid
    logic  push;  // Push, else pop
    ctxt_t ctxt;
    logic  rnd;   // Data from the LFSR, else fixed
    logic  fault; // Pop expected to hit an empty context
  } row_t;

  localparam int N_ROWS = 58;
  localparam int LIMIT  = 4 * N_ROWS + 50; // Cycle budget

  row_t rows [N_ROWS] = '{
    '{0,0,0,0,0}, '{0,0,0,0,0},                                // Idle after reset
    '{1,1,1,1,0}, '{1,1,1,0,0}, '{1,1,1,1,0},                  // Three pushes on ctxt 1
    '{1,0,1,0,0}, '{1,0,1,0,0}, '{1,0,1,0,0},                  // Popped back in order
    '{1,1,0,1,0}, '{1,1,2,1,0}, '{1,1,3,0,0}, '{1,1,0,1,0},    // Interleaved contexts
    '{1,0,2,0,0}, '{1,1,1,1,0}, '{1,0,0,0,0}, '{1,0,0,0,0},    // Slot 1 reused
    '{1,1,3,1,0}, '{1,0,3,0,0}, '{1,0,1,0,0}, '{1,0,3,0,0},
    '{1,0,2,0,1}, '{1,1,2,1,0}, '{1,0,2,0,0},                  // Faulted pop, then normal
    '{1,1,0,1,0}, '{1,1,1,1,0}, '{1,1,2,1,0}, '{1,1,3,1,0},    // Fill the pool
    '{1,1,0,1,0}, '{1,1,1,1,0}, '{1,1,2,1,0}, '{1,1,3,1,0},
    '{1,1,0,1,0}, '{1,1,1,1,0}, '{1,1,2,1,0}, '{1,1,3,1,0},
    '{1,1,0,1,0}, '{1,1,1,1,0}, '{1,1,2,1,0}, '{1,1,3,1,0},
    '{1,1,0,0,0}, '{1,0,1,0,0}, '{1,1,0,1,0},                  // Refused, pop, retry
    '{1,0,0,0,0}, '{1,0,0,0,0}, '{1,0,0,0,0}, '{1,0,0,0,0},    // Drain everything
    '{1,0,0,0,0}, '{1,0,1,0,0}, '{1,0,1,0,0}, '{1,0,1,0,0},
    '{1,0,2,0,0}, '{1,0,2,0,0}, '{1,0,2,0,0}, '{1,0,2,0,0},
    '{1,0,3,0,0}, '{1,0,3,0,0}, '{1,0,3,0,0}, '{1,0,3,0,0}
  };

  logic      clk, rst, cmd_pass, cmd_push, cmd_accept;
  ctxt_t     cmd_ctxt;
  data_t     cmd_data, lkup_data_r, exp_data;
  logic      lkup_pass_r, lkup_rnw_r, lkup_empty_fault_r, full_r;
  addr_t     lkup_addr_r, exp_addr;
  ctxt_vec_t empty_r;
  addr_t     q [`LLQ_CTXTS][$]; // Model queues, oldest first
  slot_vec_t used;              // Model slot bitset
  logic [31:0] lfsr;
  int        row, refused, cycles;
  logic      taken, prev_pop, exp_push, exp_fault;

  llq_top uut (
    .clk(clk), .rst(rst), .cmd_pass(cmd_pass), .cmd_push(cmd_push),
    .cmd_ctxt(cmd_ctxt), .cmd_data(cmd_data), .cmd_accept(cmd_accept),
    .lkup_pass_r(lkup_pass_r), .lkup_rnw_r(lkup_rnw_r), .lkup_addr_r(lkup_addr_r),
    .lkup_data_r(lkup_data_r), .lkup_empty_fault_r(lkup_empty_fault_r),
    .empty_r(empty_r), .full_r(full_r)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic draw_word(output data_t w); // One LFSR step per bit
    w = '0;
    for (int b = 0; b < `LLQ_DATA_W; b++) begin
      w    = {w[`LLQ_DATA_W-2:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic drive_row(input int r);
    cmd_pass = rows[r].pass;
    cmd_push = rows[r].push;
    cmd_ctxt = rows[r].ctxt;
    if (rows[r].rnd)
      draw_word(cmd_data);
    else
      cmd_data = {24'h5a0000, 8'(r)}; // Row-tagged fixed word
  endtask

  // Model update for a command about to be taken at the next edge
  task automatic predict_cmd();
    int s;
    exp_push  = cmd_push;
    exp_data  = cmd_data;
    exp_fault = 1'b0;
    if (cmd_push) begin
      s = 0;
      while (used[s])
        s++;                         // Lowest free slot
      exp_addr = addr_t'(s);
      used[s]  = 1'b1;
      q[cmd_ctxt].push_back(exp_addr);
    end else if (q[cmd_ctxt].size() == 0) begin
      exp_fault = 1'b1;
    end else begin
      exp_addr       = q[cmd_ctxt].pop_front();
      used[exp_addr] = 1'b0;
    end
    if (exp_fault != rows[row].fault) begin
      fail_count++;
      $display("table row %0d disagrees with the model about an empty-context pop", row);
    end
  endtask

  function automatic ctxt_vec_t model_empty();
    ctxt_vec_t v;
    for (int c = 0; c < `LLQ_CTXTS; c++)
      v[c] = (q[c].size() == 0);
    return v;
  endfunction

  initial begin
    cmd_pass = 1'b0;
    cmd_push = 1'b0;
    cmd_ctxt = '0;
    cmd_data = '0;
    rst      = 1'b1;
    lfsr     = 32'hfbd544cb;
    used     = '0;
    prev_pop = 1'b0;
    refused  = 0;
    row      = 0;
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;
    drive_row(row);
    while (row < N_ROWS) begin
      @(negedge clk);                // Accept is stable mid-cycle
      bit_cmp("cmd_accept", cmd_accept, !prev_pop && !(cmd_push && (&used)));
      taken = cmd_pass && cmd_accept;
      if (taken)
        predict_cmd();
      @(posedge clk);
      #1;
      bit_cmp("lkup_pass_r", lkup_pass_r, taken);
      if (taken) begin
        bit_cmp("lkup_rnw_r", lkup_rnw_r, !exp_push);
        bit_cmp("lkup_empty_fault_r", lkup_empty_fault_r, rows[row].fault);
        if (!exp_fault)
          addr_cmp("lkup_addr_r", lkup_addr_r, exp_addr);
        if (exp_push)
          data_cmp("lkup_data_r", lkup_data_r, exp_data);
      end
      vec_cmp("empty_r", empty_r, model_empty());
      bit_cmp("full_r", full_r, &used);
      prev_pop = taken && !cmd_push;
      if (cmd_pass && !taken && cmd_push && (&used))
        refused++;                   // Held push against a full pool
      if (taken || !cmd_pass || refused == 3) begin
        refused = 0;                 // Withdrawn after three refusals
        row++;
        if (row < N_ROWS)
          drive_row(row);
        else
          cmd_pass = 1'b0;
      end
    end
    repeat (2) @(posedge clk);
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    fail_count++;
    $display("timeout: the command table did not finish within %0d cycles", LIMIT);
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+.
llq_pkg.sv
llq_intf.sv
llq_cntrl.sv
llq_free_list.sv
llq_state_table.sv
llq_link_table.sv
llq_top.sv
tb_llq.sv

// ==== Makefile ====
TOOL    = verilator
FLAGS   = --binary --timing --assert -j 0
TOP     = tb_llq
RTL_TOP = llq_top
FLIST   = vlog.f
BIN     = obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "^STATUS: PASS$$"

lint:
	$(TOOL) --lint-only --timing --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf obj_dir
